//--- Bender.yml
package:
  name: sprite_engine

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/spritePkg.sv
      - hw/spriteRegs.sv
      - hw/spriteLayer.sv
      - hw/layerCompositor.sv
      - hw/spriteEngine.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/spriteEngine_properties.sv
      - tests/spriteEngine_tb.sv

//--- hw/layerCompositor.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"

module layerCompositor
  import spritePkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  layerMask_t hitMask,
  input  colour_t    layerColour [`NUM_LAYERS],
  input  logic       pixValidD,

  output logic       outValid,
  output logic       outCovered,
  output colour_t    outColour
);

  layerMask_t layerOH;    // Most significant set bit of hitMask, one-hot
  colour_t    selColour;

  // Scan upwards so the highest hit layer is the last to claim the bit
  always_comb begin
    layerOH = '0;
    for (int i = 0; i < `NUM_LAYERS; i++) begin
      if (hitMask[i]) begin
        layerOH = layerMask_t'(1) << i;
      end
    end
  end

  // AND-OR mux, an empty one-hot leaves black
  always_comb begin
    selColour = '0;
    for (int i = 0; i < `NUM_LAYERS; i++) begin
      if (layerOH[i]) begin
        selColour = selColour | layerColour[i];
      end
    end
  end

  // Second pipeline stage, two cycles after the pixel entered the engine
  always_ff @(posedge clk) begin
    if (reset) begin
      outValid   <= 1'b0;
      outCovered <= 1'b0;
      outColour  <= '0;
    end else begin
      outValid   <= pixValidD;
      outCovered <= |layerOH;  // Layer hits already include valid
      outColour  <= selColour;
    end
  end

endmodule

//--- hw/spriteEngine.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"

module spriteEngine
  import spritePkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  logic    wbCyc,
  input  logic    wbStb,
  input  logic    wbWe,
  input  wbAddr_t wbAdr,
  input  wbData_t wbDatW,
  output wbData_t wbDatR,
  output logic    wbAck,

  input  pixelX_t pixX,
  input  pixelY_t pixY,
  input  logic    pixValid,

  output logic    outValid,
  output logic    outCovered,
  output colour_t outColour
);

  // Register bank to layers
  pixelX_t    posX   [`NUM_LAYERS];
  pixelY_t    posY   [`NUM_LAYERS];
  pixelX_t    width  [`NUM_LAYERS];
  pixelY_t    height [`NUM_LAYERS];
  colour_t    colour [`NUM_LAYERS];
  layerMask_t enable;

  // Layers to compositor
  layerMask_t hitMask;
  colour_t    layerColour [`NUM_LAYERS];
  layerMask_t layerValid;  // Identical copies, bit 0 feeds the compositor

  spriteRegs regs (
    .clk    (clk),
    .reset  (reset),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck),
    .posX   (posX),
    .posY   (posY),
    .width  (width),
    .height (height),
    .colour (colour),
    .enable (enable)
  );

  for (genvar i = 0; i < `NUM_LAYERS; i++) begin : genLayer
    spriteLayer layer (
      .clk       (clk),
      .reset     (reset),
      .pixX      (pixX),
      .pixY      (pixY),
      .pixValid  (pixValid),
      .posX      (posX[i]),
      .posY      (posY[i]),
      .width     (width[i]),
      .height    (height[i]),
      .colour    (colour[i]),
      .enable    (enable[i]),
      .hit       (hitMask[i]),
      .hitColour (layerColour[i]),
      .validD    (layerValid[i])
    );
  end

  layerCompositor comp (
    .clk         (clk),
    .reset       (reset),
    .hitMask     (hitMask),
    .layerColour (layerColour),
    .pixValidD   (layerValid[0]),
    .outValid    (outValid),
    .outCovered  (outCovered),
    .outColour   (outColour)
  );

endmodule

//--- hw/spriteLayer.sv
`timescale 1ns/1ns

module spriteLayer
  import spritePkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  pixelX_t pixX,
  input  pixelY_t pixY,
  input  logic    pixValid,

  input  pixelX_t posX,
  input  pixelY_t posY,
  input  pixelX_t width,
  input  pixelY_t height,
  input  colour_t colour,
  input  logic    enable,

  output logic    hit,
  output colour_t hitColour,
  output logic    validD
);

  // Right and bottom edges need one extra bit so posX + width cannot wrap
  logic [$bits(pixelX_t):0] xEnd;
  logic [$bits(pixelY_t):0] yEnd;
  logic                     inX;
  logic                     inY;
  logic                     covers;

  assign xEnd = {1'b0, posX} + {1'b0, width};
  assign yEnd = {1'b0, posY} + {1'b0, height};

  // Left and top edges are inclusive, right and bottom edges are exclusive
  assign inX = (pixX >= posX) && ({1'b0, pixX} < xEnd);
  assign inY = (pixY >= posY) && ({1'b0, pixY} < yEnd);

  // A zero width or height leaves the range empty and nothing is covered
  assign covers = enable && pixValid && inX && inY;

  // Flag and valid are control state
  always_ff @(posedge clk) begin
    if (reset) begin
      hit    <= 1'b0;
      validD <= 1'b0;
    end else begin
      hit    <= covers;
      validD <= pixValid;  // Every layer delays valid, the top uses layer 0
    end
  end

  // Colour rides along with the flag so both describe the same pixel
  always_ff @(posedge clk) begin
    hitColour <= colour;
  end

endmodule

//--- hw/spritePkg.sv
`include "sprite_defs.svh"

package spritePkg;

  // Horizontal coordinate, 0 to 639, also carries a sprite width
  typedef logic [9:0] pixelX_t;

  // Vertical coordinate, 0 to 479, also carries a sprite height
  typedef logic [8:0] pixelY_t;

  // Red in bits 23..16, green in 15..8, blue in 7..0
  typedef logic [23:0] colour_t;

  // Word address covering 5 layers of 4 registers plus an unused upper range
  typedef logic [4:0] wbAddr_t;

  // Full Wishbone data word
  typedef logic [31:0] wbData_t;

  // One bit per layer, bit index equals layer index
  typedef logic [`NUM_LAYERS-1:0] layerMask_t;

endpackage

//--- hw/spriteRegs.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"

module spriteRegs
  import spritePkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  logic       wbCyc,
  input  logic       wbStb,
  input  logic       wbWe,
  input  wbAddr_t    wbAdr,
  input  wbData_t    wbDatW,
  output wbData_t    wbDatR,
  output logic       wbAck,

  output pixelX_t    posX   [`NUM_LAYERS],
  output pixelY_t    posY   [`NUM_LAYERS],
  output pixelX_t    width  [`NUM_LAYERS],
  output pixelY_t    height [`NUM_LAYERS],
  output colour_t    colour [`NUM_LAYERS],
  output layerMask_t enable
);

  // Address split into layer index and register offset
  localparam int unsigned OffW = $clog2(`REGS_PER_LAYER);
  localparam int unsigned IdxW = $bits(wbAddr_t) - OffW;

  // X and Y fields share the same packing in POS and SIZE
  localparam int unsigned XLsb = 0;
  localparam int unsigned YLsb = 16;
  localparam int unsigned XW   = $bits(pixelX_t);
  localparam int unsigned YW   = $bits(pixelY_t);
  localparam int unsigned CW   = $bits(colour_t);

  logic [IdxW-1:0] layerIdx;
  logic [OffW-1:0] regOff;
  logic            layerOk;  // High when the address falls inside a real layer
  logic            reqValid;
  logic            wrValid;
  wbData_t         readWord;

  assign layerIdx = wbAdr[$bits(wbAddr_t)-1:OffW];
  assign regOff   = wbAdr[OffW-1:0];
  assign layerOk  = (layerIdx < `NUM_LAYERS);  // Addresses 20 to 31 map to no layer

  // A request is taken only when no ack is pending, so ack can never repeat
  assign reqValid = wbCyc && wbStb && !wbAck;
  assign wrValid  = reqValid && wbWe && layerOk;

  // Read mux, every bit outside a field stays zero
  always_comb begin
    readWord = '0;
    if (layerOk) begin
      case (regOff)
        `REG_POS: begin
          readWord[XLsb +: XW] = posX[layerIdx];
          readWord[YLsb +: YW] = posY[layerIdx];
        end
        `REG_SIZE: begin
          readWord[XLsb +: XW] = width[layerIdx];
          readWord[YLsb +: YW] = height[layerIdx];
        end
        `REG_COLOUR: readWord[CW-1:0] = colour[layerIdx];
        default:     readWord[0] = enable[layerIdx];  // CTRL holds only the enable bit
      endcase
    end
  end

  // Ack and all sprite state
  always_ff @(posedge clk) begin
    if (reset) begin
      wbAck <= 1'b0;
      for (int i = 0; i < `NUM_LAYERS; i++) begin
        posX[i]   <= '0;
        posY[i]   <= '0;
        width[i]  <= '0;
        height[i] <= '0;
        colour[i] <= '0;
      end
      enable <= '0;  // All layers start hidden
    end else begin
      wbAck <= reqValid;  // Exactly one cycle after the request

      // The write lands together with the ack, so pixels after the ack see it
      if (wrValid) begin
        case (regOff)
          `REG_POS: begin
            posX[layerIdx] <= wbDatW[XLsb +: XW];
            posY[layerIdx] <= wbDatW[YLsb +: YW];
          end
          `REG_SIZE: begin
            width[layerIdx]  <= wbDatW[XLsb +: XW];
            height[layerIdx] <= wbDatW[YLsb +: YW];
          end
          `REG_COLOUR: colour[layerIdx] <= wbDatW[CW-1:0];
          default:     enable[layerIdx] <= wbDatW[0];
        endcase
      end
    end
  end

  // Read data is captured on the same edge that raises the ack
  always_ff @(posedge clk) begin
    if (reqValid) begin
      wbDatR <= readWord;
    end
  end

endmodule

//--- hw/sprite_defs.svh
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// Number of rectangle layers, layer 4 sits on top
`define NUM_LAYERS 5

// Visible area of the VGA stream
`define SCREEN_W 640
`define SCREEN_H 480

// Word offsets inside one layer's register block
`define REG_POS    2'd0
`define REG_SIZE   2'd1
`define REG_COLOUR 2'd2
`define REG_CTRL   2'd3

// Each layer owns four consecutive words, so word address = layer * 4 + offset
`define REGS_PER_LAYER 4

`endif

//--- project.f
+incdir+hw
hw/spritePkg.sv
hw/spriteRegs.sv
hw/spriteLayer.sv
hw/layerCompositor.sv
hw/spriteEngine.sv
tests/spriteEngine_properties.sv
tests/spriteEngine_tb.sv

//--- tests/spriteEngine_properties.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"

module spriteEngine_properties
  import spritePkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    wbCyc,
  input logic    wbStb,
  input logic    wbAck,
  input pixelX_t pixX,
  input pixelY_t pixY,
  input logic    pixValid,
  input logic    outValid,
  input logic    outCovered
);

  int unsigned failCount = 0;  // Number of assertion failures so far

  // Slave is idle for a cycle after every ack
  ackSingle: assert property (@(posedge clk) disable iff (reset) wbAck |=> !wbAck)
    else begin
      $error("wbAck high in two cycles in a row");
      failCount++;
    end

  ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
    wbAck |-> $past(wbCyc && wbStb))
    else begin
      $error("wbAck without a request in the cycle before");
      failCount++;
    end

  // Two register stages between pixel in and pixel out
  validLatency: assert property (@(posedge clk) disable iff (reset)
    outValid == $past(pixValid, 2))
    else begin
      $error("outValid does not follow pixValid by two cycles");
      failCount++;
    end

  coveredNeedsValid: assert property (@(posedge clk) disable iff (reset)
    outCovered |-> outValid)
    else begin
      $error("outCovered high while outValid is low");
      failCount++;
    end

  pixelOnScreen: assert property (@(posedge clk) disable iff (reset)
    pixValid |-> (pixX < `SCREEN_W && pixY < `SCREEN_H))  // Stream stays inside 640x480
    else begin
      $error("Pixel coordinate outside the visible area");
      failCount++;
    end

endmodule

bind spriteEngine spriteEngine_properties props (
  .clk        (clk),
  .reset      (reset),
  .wbCyc      (wbCyc),
  .wbStb      (wbStb),
  .wbAck      (wbAck),
  .pixX       (pixX),
  .pixY       (pixY),
  .pixValid   (pixValid),
  .outValid   (outValid),
  .outCovered (outCovered)
);

//--- tests/spriteEngine_tb.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"

module spriteEngine_tb
  import spritePkg::*;
();

  localparam int AckTimeout   = 16;  // Cycles a bus access may wait for wbAck
  localparam int DrainTimeout = 16;
  localparam int Latency      = 2;   // Pixel in to pixel out

  logic       clk;
  logic       reset;
  logic       wbCyc;
  logic       wbStb;
  logic       wbWe;
  wbAddr_t    wbAdr;
  wbData_t    wbDatW;
  wbData_t    wbDatR;
  logic       wbAck;
  pixelX_t    pixX;
  pixelY_t    pixY;
  logic       pixValid;
  logic       outValid;
  logic       outCovered;
  colour_t    outColour;

  // Copy of every register as the host wrote it
  pixelX_t    shPosX   [`NUM_LAYERS];
  pixelY_t    shPosY   [`NUM_LAYERS];
  pixelX_t    shWidth  [`NUM_LAYERS];
  pixelY_t    shHeight [`NUM_LAYERS];
  colour_t    shColour [`NUM_LAYERS];
  layerMask_t shEnable;

  logic [24:0] expPixel [$];  // Covered flag on top of the colour
  int          expCycle [$];  // Cycle in which the pixel entered
  int          cycleCount = 0;
  logic [31:0] lfsr;

  spriteEngine UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  // Galois LFSR stepped once for every bit handed out
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Topmost enabled rectangle that holds the pixel with right and bottom edges excluded
  function automatic logic [24:0] expectedPixel(input pixelX_t x, input pixelY_t y);
    logic [24:0] result;
    result = '0;
    for (int i = 0; i < `NUM_LAYERS; i++) begin
      if (shEnable[i] && x >= shPosX[i] && int'(x) < int'(shPosX[i]) + int'(shWidth[i])
          && y >= shPosY[i] && int'(y) < int'(shPosY[i]) + int'(shHeight[i]))
        result = {1'b1, shColour[i]};  // Higher layers overwrite lower ones
    end
    return result;
  endfunction

  function automatic wbData_t expectedRead(input wbAddr_t addr);
    wbData_t word;
    int      layer;
    word  = '0;
    layer = addr / `REGS_PER_LAYER;
    if (layer < `NUM_LAYERS) begin  // Words 20 to 31 read zero
      case (addr[1:0])
        `REG_POS:    word = {7'd0, shPosY[layer], 6'd0, shPosX[layer]};
        `REG_SIZE:   word = {7'd0, shHeight[layer], 6'd0, shWidth[layer]};
        `REG_COLOUR: word = {8'd0, shColour[layer]};
        default:     word = {31'd0, shEnable[layer]};
      endcase
    end
    return word;
  endfunction

  task automatic reportMismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "Stopping at the first mismatch");
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic compareColour(input colour_t got, input colour_t exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s is %06h, expected %06h", what, got, exp));
  endtask

  task automatic compareFlag(input logic got, input logic exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic compareData(input wbData_t got, input wbData_t exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s is %08h, expected %08h", what, got, exp));
  endtask

  // Entered and left at 1 ns after a rising edge
  task automatic waitAck(input string what);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    while (wbAck !== 1'b1 && waited < AckTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (wbAck !== 1'b1) abortRun($sformatf("No wbAck within %0d cycles on %s", AckTimeout, what));
  endtask

  task automatic wbWrite(input wbAddr_t addr, input wbData_t data);
    int layer;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = addr;
    wbDatW = data;
    waitAck($sformatf("write to word %0d", addr));
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    layer  = addr / `REGS_PER_LAYER;
    if (layer < `NUM_LAYERS) begin  // The slave keeps only the field bits
      case (addr[1:0])
        `REG_POS: begin
          shPosX[layer] = data[9:0];
          shPosY[layer] = data[24:16];
        end
        `REG_SIZE: begin
          shWidth[layer]  = data[9:0];
          shHeight[layer] = data[24:16];
        end
        `REG_COLOUR: shColour[layer] = data[23:0];
        default:     shEnable[layer] = data[0];
      endcase
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wbRead(input wbAddr_t addr, output wbData_t data);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe  = 1'b0;
    wbAdr = addr;
    waitAck($sformatf("read of word %0d", addr));
    data  = wbDatR;  // Held stable while wbAck is high
    wbCyc = 1'b0;
    wbStb = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic checkRead(input wbAddr_t addr);
    wbData_t got;
    wbRead(addr, got);
    compareData(got, expectedRead(addr), $sformatf("Read of word %0d", addr));
  endtask

  task automatic setupLayer(input int layer, input pixelX_t x, input pixelY_t y,
                            input pixelX_t w, input pixelY_t h, input colour_t c,
                            input logic en);
    wbAddr_t base;
    base = wbAddr_t'(layer * `REGS_PER_LAYER);
    wbWrite(base + `REG_POS, {7'd0, y, 6'd0, x});
    wbWrite(base + `REG_SIZE, {7'd0, h, 6'd0, w});
    wbWrite(base + `REG_COLOUR, {8'd0, c});
    wbWrite(base + `REG_CTRL, {31'd0, en});
  endtask

  // One pixel per cycle with its expectation taken from the registers in force now
  task automatic drivePixel(input pixelX_t x, input pixelY_t y, input logic valid);
    pixX     = x;
    pixY     = y;
    pixValid = valid;
    if (valid) begin
      expPixel.push_back(expectedPixel(x, y));
      expCycle.push_back(cycleCount);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic drainPixels();
    int waited;
    pixValid = 1'b0;
    waited   = 0;
    while (expCycle.size() != 0 && waited < DrainTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (expCycle.size() != 0)
      abortRun($sformatf("%0d pixel results still missing after %0d idle cycles",
                         expCycle.size(), DrainTimeout));
  endtask

  // Diagonal through the overlap of layers 1, 3 and 4
  task automatic driveDiagonal();
    for (int k = 190; k < 360; k++) drivePixel(pixelX_t'(k), pixelY_t'(k - 100), 1'b1);
    drainPixels();
  endtask

  // Outputs settle on the rising edge, so look at them on the falling one
  always @(negedge clk) begin : compareOutputs
    logic [24:0] expected;
    int          entered;
    if (!reset && outValid === 1'b1) begin
      if (expCycle.size() == 0) begin
        abortRun("outValid was high while no pixel result was expected");
      end else begin
        expected = expPixel.pop_front();
        entered  = expCycle.pop_front();
        compareFlag(outCovered, expected[24], "outCovered");
        compareColour(outColour, expected[23:0], "outColour");
        if (cycleCount - entered != Latency)
          reportMismatch($sformatf("Pixel latency %0d cycles", cycleCount - entered));
      end
    end else if (!reset) begin
      // An idle slot carries no hit, so the output is black and uncovered
      compareFlag(outCovered, 1'b0, "outCovered without outValid");
      compareColour(outColour, '0, "outColour without outValid");
    end
  end

  // The bound checker counts its assertion failures
  always @(negedge clk) begin
    if (UUT.props.failCount != 0) abortRun("A bound assertion on the engine failed");
  end

  initial begin
    pixelX_t x;
    pixelY_t y;
    pixelX_t w;
    pixelY_t h;
    colour_t c;
    logic    en;
    lfsr     = 32'h2de0_dd1f;
    reset    = 1'b1;
    wbCyc    = 1'b0;
    wbStb    = 1'b0;
    wbWe     = 1'b0;
    wbAdr    = '0;
    wbDatW   = '0;
    pixX     = '0;
    pixY     = '0;
    pixValid = 1'b0;
    shEnable = '0;
    for (int i = 0; i < `NUM_LAYERS; i++) begin
      shPosX[i]   = '0;
      shPosY[i]   = '0;
      shWidth[i]  = '0;
      shHeight[i] = '0;
      shColour[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    compareFlag(wbAck, 1'b0, "wbAck after reset");
    compareFlag(outValid, 1'b0, "outValid after reset");
    compareFlag(outCovered, 1'b0, "outCovered after reset");
    compareColour(outColour, '0, "outColour after reset");

    // Reset contents and an empty screen line
    for (int a = 0; a < 32; a++) checkRead(wbAddr_t'(a));
    for (int k = 0; k < `SCREEN_W; k++) drivePixel(pixelX_t'(k), 9'd240, 1'b1);
    drainPixels();

    // Random words everywhere including the upper range
    for (int a = 0; a < 32; a++) wbWrite(wbAddr_t'(a), randBits(32));
    for (int a = 0; a < 32; a++) checkRead(wbAddr_t'(a));

    // Lone rectangle scanned across all four edges
    for (int i = 0; i < `NUM_LAYERS; i++) wbWrite(wbAddr_t'(i * `REGS_PER_LAYER + 3), '0);
    setupLayer(2, 10'd100, 9'd50, 10'd20, 9'd10, 24'h3ca55a, 1'b1);
    for (int yy = 48; yy <= 62; yy++)
      for (int xx = 98; xx <= 122; xx++) drivePixel(pixelX_t'(xx), pixelY_t'(yy), 1'b1);
    drainPixels();

    // Stacked layers with the top two then switched off one by one
    setupLayer(1, 10'd200, 9'd100, 10'd100, 9'd100, 24'hff0000, 1'b1);
    setupLayer(3, 10'd250, 9'd150, 10'd100, 9'd100, 24'h00ff00, 1'b1);
    setupLayer(4, 10'd260, 9'd160, 10'd20, 9'd20, 24'h0000ff, 1'b1);
    driveDiagonal();
    wbWrite(wbAddr_t'(4 * `REGS_PER_LAYER + 3), '0);
    driveDiagonal();
    wbWrite(wbAddr_t'(3 * `REGS_PER_LAYER + 3), '0);
    driveDiagonal();

    // Random scenes with random gaps in the pixel stream
    for (int round = 0; round < 6; round++) begin
      for (int i = 0; i < `NUM_LAYERS; i++) begin
        x  = pixelX_t'(randBits(10) % `SCREEN_W);
        y  = pixelY_t'(randBits(9) % `SCREEN_H);
        w  = pixelX_t'(randBits(8));
        h  = pixelY_t'(randBits(8));
        c  = colour_t'(randBits(24));
        en = (randBits(1) != 0);
        setupLayer(i, x, y, w, h, c, en);
      end
      for (int n = 0; n < 300; n++) begin
        x  = pixelX_t'(randBits(10) % `SCREEN_W);
        y  = pixelY_t'(randBits(9) % `SCREEN_H);
        en = (randBits(3) != 0);  // Roughly one gap in eight cycles
        drivePixel(x, y, en);
      end
      drainPixels();
    end

    if (UUT.props.failCount != 0) begin
      abortRun($sformatf("%0d bound assertion failures", UUT.props.failCount));
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule
